// ==== design/ethFramePkg.sv ====
// Frame beat definitions shared by the switch datapath.
// Beat status code, port widths and FIFO entry widths.
// Modules import it inside their body; ports use scoped names.
`default_nettype none

package ethFramePkg;

  // Beat status, last in bit 1, first in bit 0
  typedef enum logic [1:0] {
    stMid   = 2'b00,
    stFirst = 2'b01,
    stLast  = 2'b10,
    stOnly  = 2'b11
  } ethSt;

  localparam int byteW    = 8;            // Ports 0 to 2
  localparam int wordW    = 16;           // Port 3
  localparam int numPorts = 4;
  localparam int wordPort = 3;            // Index of the word port
  localparam int byteEntW = byteW + 2;    // FIFO entry, status on top
  localparam int wordEntW = wordW + 2;

  function automatic logic isFirst(ethSt st);
    return (st == stFirst) || (st == stOnly);
  endfunction

  function automatic logic isLast(ethSt st);
    return (st == stLast) || (st == stOnly);
  endfunction

  // Build a status from its two flags
  function automatic ethSt mkSt(logic last, logic first);
    return ethSt'({last, first});
  endfunction

endpackage

`default_nettype wire

// ==== design/switchCfgPkg.sv ====
// Switch configuration constants.
// FIFO sizing for every input/output path and the egress scheduler states.
`default_nettype none

package switchCfgPkg;

  localparam int fifoDepth = 64;                 // Entries per path FIFO
  localparam int fifoAw    = $clog2(fifoDepth);  // 6 address bits

  // Egress scheduler
  typedef enum logic {
    egIdle = 1'b0,   // No source held
    egSend = 1'b1    // Source held until its last beat
  } egState;

endpackage

`default_nettype wire

// ==== design/pktFifo.sv ====
// Synchronous show-ahead FIFO for one switch path.
// Each entry holds a data beat with its status on top.
// rdData shows the head entry while empty is low; rdEn pops it.
// Writes into a full FIFO and reads from an empty one are ignored.
`default_nettype none
`timescale 1ns/1ns

module pktFifo #(
  parameter int dataW = 10
) (
  input  wire              RxClk,
  input  wire              arstN,
  input  wire              wrEn,
  input  wire [dataW-1:0]  wrData,
  input  wire              rdEn,
  output logic [dataW-1:0] rdData,
  output logic             empty,
  output logic             full
);
  import switchCfgPkg::*;

  logic [dataW-1:0] mem [fifoDepth];
  logic [fifoAw-1:0] wrPtr;
  logic [fifoAw-1:0] rdPtr;
  logic [fifoAw:0]   count;    // One extra bit to tell full from empty
  logic doWr;
  logic doRd;

  assign full  = (count == (fifoAw + 1)'(fifoDepth));
  assign empty = (count == '0);
  assign doWr  = wrEn && !full;     // Beat lost when full
  assign doRd  = rdEn && !empty;

  assign rdData = mem[rdPtr];       // Head shown ahead of the pop

  always_ff @(posedge RxClk) begin
    if (doWr) mem[wrPtr] <= wrData;
  end

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWr) wrPtr <= wrPtr + 1'b1;   // Wraps at depth
      if (doRd) rdPtr <= rdPtr + 1'b1;
      case ({doWr, doRd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/bytePacker.sv ====
// Packs a byte-port frame into words for the 16-bit port.
// The first byte of each pair goes in bits 15 to 8.
// wrEn is high in the cycle of the second byte, so the word is written
// on that edge; a byte marked first always restarts the pairing.
`default_nettype none
`timescale 1ns/1ns

module bytePacker (
  input  wire                               RxClk,
  input  wire                               arstN,
  input  wire                               rxValid,
  input  wire [ethFramePkg::byteW-1:0]      rxD,
  input  wire ethFramePkg::ethSt            rxSt,
  output logic                              wrEn,
  output logic [ethFramePkg::wordEntW-1:0]  wrData
);
  import ethFramePkg::*;

  logic [byteW-1:0] hiByte;   // Pending high byte
  logic hiFirst;              // Its first flag
  logic pend;                 // High byte waiting for a partner
  logic restart;

  assign restart = isFirst(rxSt);

  // Word status takes first from the high byte, last from the low byte
  assign wrEn   = rxValid && pend && !restart;
  assign wrData = {mkSt(isLast(rxSt), hiFirst), hiByte, rxD};

  always_ff @(posedge RxClk) begin
    if (rxValid && (restart || !pend)) hiByte <= rxD;
  end

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      pend    <= 1'b0;
      hiFirst <= 1'b0;
    end else if (rxValid) begin
      if (restart || !pend) begin
        pend    <= 1'b1;          // Start a new pair
        hiFirst <= restart;
      end else begin
        pend <= 1'b0;             // Pair went out this cycle
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/wordUnpacker.sv ====
// Splits words from a port-3 FIFO into bytes for one byte port.
// The high byte goes first and keeps the word's first flag; the low byte
// follows with the word's last flag. The FIFO is popped when the low
// byte is taken, so the word stays at the head for both halves.
`default_nettype none
`timescale 1ns/1ns

module wordUnpacker (
  input  wire                               RxClk,
  input  wire                               arstN,
  input  wire                               fifoEmpty,
  input  wire [ethFramePkg::wordEntW-1:0]   fifoData,
  output logic                              txValid,
  output logic [ethFramePkg::byteW-1:0]     txD,
  output ethFramePkg::ethSt                 txSt,
  input  wire                               txReady,
  output logic                              fifoRd
);
  import ethFramePkg::*;

  logic loSel;      // 0 high byte pending, 1 low byte pending
  logic accept;
  ethSt wordSt;

  assign wordSt  = ethSt'(fifoData[wordEntW-1:wordW]);
  assign txValid = !fifoEmpty;
  assign accept  = txValid && txReady;
  assign fifoRd  = accept && loSel;   // Word done after its low byte

  always_comb begin
    if (loSel) begin
      txD  = fifoData[byteW-1:0];
      txSt = mkSt(isLast(wordSt), 1'b0);
    end else begin
      txD  = fifoData[wordW-1:byteW];
      txSt = mkSt(1'b0, isFirst(wordSt));   // stOnly word splits to first, last
    end
  end

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      loSel <= 1'b0;
    end else if (accept) begin
      loSel <= !loSel;    // Toggle per accepted byte
    end
  end

endmodule

`default_nettype wire

// ==== design/portEgress.sv ====
// Egress scheduler for one output port.
// Picks one of three sources in round-robin order and keeps it until its
// beat marked last is accepted; one idle cycle follows every frame.
// TxValid rises the cycle after the pick. Each accepted beat pops the
// held source, and TxD/TxSt come straight from its head, so they hold
// while TxReady is low.
`default_nettype none
`timescale 1ns/1ns

module portEgress #(
  parameter int dataW = 8
) (
  input  wire                     RxClk,
  input  wire                     arstN,
  input  wire [2:0]               srcValid,
  input  wire [dataW-1:0]         srcData0,
  input  wire [dataW-1:0]         srcData1,
  input  wire [dataW-1:0]         srcData2,
  input  wire ethFramePkg::ethSt  srcSt0,
  input  wire ethFramePkg::ethSt  srcSt1,
  input  wire ethFramePkg::ethSt  srcSt2,
  output logic [2:0]              srcPop,
  input  wire                     TxReady,
  output logic                    TxValid,
  output logic [dataW-1:0]        TxD,
  output ethFramePkg::ethSt       TxSt
);
  import ethFramePkg::*;
  import switchCfgPkg::*;

  egState egSt;
  logic [1:0] heldSrc;   // Held source, doubles as last-served pointer
  logic [1:0] nextSrc;
  logic accept;

  // Round robin, starting at the source after the one last served
  always_comb begin
    int cand;
    nextSrc = heldSrc;
    for (int i = 3; i >= 1; i--) begin
      cand = (int'(heldSrc) + i) % 3;
      if (srcValid[cand]) nextSrc = 2'(cand);   // Nearest one wins
    end
  end

  // Output mux from the held source
  always_comb begin
    case (heldSrc)
      2'd0: begin
        TxD  = srcData0;
        TxSt = srcSt0;
      end
      2'd1: begin
        TxD  = srcData1;
        TxSt = srcSt1;
      end
      default: begin
        TxD  = srcData2;
        TxSt = srcSt2;
      end
    endcase
  end

  assign TxValid = (egSt == egSend) && srcValid[heldSrc];   // Gaps in the frame show as low
  assign accept  = TxValid && TxReady;
  assign srcPop  = accept ? (3'b001 << heldSrc) : 3'b000;

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      egSt    <= egIdle;
      heldSrc <= 2'd0;
    end else begin
      case (egSt)
        egIdle: begin
          if (|srcValid) begin
            heldSrc <= nextSrc;
            egSt    <= egSend;
          end
        end
        egSend: begin
          if (accept && isLast(TxSt)) egSt <= egIdle;   // Frame lock released
        end
        default: egSt <= egIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/ethSwitch.sv ====
// Four-port Ethernet switch top level, all on RxClk.
// Ports 0 to 2 carry bytes, port 3 carries 16-bit words, high byte first.
// Each frame is flooded to the other three ports through its own FIFO;
// byte-to-word paths pack, word-to-byte paths unpack.
// Output n takes sources n+1, n+2 and n+3 modulo 4, in that order.
`default_nettype none
`timescale 1ns/1ns

module ethSwitch (
  input  wire                           RxClk,
  input  wire                           arstN,

  input  wire                           P0RxValid,
  input  wire [ethFramePkg::byteW-1:0]  P0RxD,
  input  wire ethFramePkg::ethSt        P0RxSt,
  input  wire                           P0TxReady,
  output logic                          P0TxValid,
  output logic [ethFramePkg::byteW-1:0] P0TxD,
  output ethFramePkg::ethSt             P0TxSt,

  input  wire                           P1RxValid,
  input  wire [ethFramePkg::byteW-1:0]  P1RxD,
  input  wire ethFramePkg::ethSt        P1RxSt,
  input  wire                           P1TxReady,
  output logic                          P1TxValid,
  output logic [ethFramePkg::byteW-1:0] P1TxD,
  output ethFramePkg::ethSt             P1TxSt,

  input  wire                           P2RxValid,
  input  wire [ethFramePkg::byteW-1:0]  P2RxD,
  input  wire ethFramePkg::ethSt        P2RxSt,
  input  wire                           P2TxReady,
  output logic                          P2TxValid,
  output logic [ethFramePkg::byteW-1:0] P2TxD,
  output ethFramePkg::ethSt             P2TxSt,

  input  wire                           P3RxValid,
  input  wire [ethFramePkg::wordW-1:0]  P3RxD,
  input  wire ethFramePkg::ethSt        P3RxSt,
  input  wire                           P3TxReady,
  output logic                          P3TxValid,
  output logic [ethFramePkg::wordW-1:0] P3TxD,
  output ethFramePkg::ethSt             P3TxSt
);
  import ethFramePkg::*;

  // Receive side as arrays, bytes for ports 0 to 2 only
  wire rxValid [numPorts];
  wire ethSt rxSt [numPorts];
  wire [byteW-1:0] rxByte [wordPort];

  assign rxValid[0] = P0RxValid;
  assign rxValid[1] = P1RxValid;
  assign rxValid[2] = P2RxValid;
  assign rxValid[3] = P3RxValid;
  assign rxSt[0]    = P0RxSt;
  assign rxSt[1]    = P1RxSt;
  assign rxSt[2]    = P2RxSt;
  assign rxSt[3]    = P3RxSt;
  assign rxByte[0]  = P0RxD;
  assign rxByte[1]  = P1RxD;
  assign rxByte[2]  = P2RxD;

  // Byte-port transmit side
  wire txReady [wordPort];
  wire txValid [wordPort];
  wire [byteW-1:0] txByte [wordPort];
  wire ethSt txSt [wordPort];

  assign txReady[0] = P0TxReady;
  assign txReady[1] = P1TxReady;
  assign txReady[2] = P2TxReady;
  assign P0TxValid  = txValid[0];
  assign P1TxValid  = txValid[1];
  assign P2TxValid  = txValid[2];
  assign P0TxD      = txByte[0];
  assign P1TxD      = txByte[1];
  assign P2TxD      = txByte[2];
  assign P0TxSt     = txSt[0];
  assign P1TxSt     = txSt[1];
  assign P2TxSt     = txSt[2];

  // Path heads per output, index k is source (out + k + 1) mod 4
  wire [2:0] bpVld [wordPort];
  wire [2:0] bpPop [wordPort];
  wire [byteW-1:0] bpD [wordPort][3];
  wire ethSt bpSt [wordPort][3];
  wire [2:0] wpVld;                 // Paths into port 3
  wire [2:0] wpPop;
  wire [wordW-1:0] wpD [3];
  wire ethSt wpSt [3];

  for (genvar d = 0; d < numPorts; d++) begin : gOut
    for (genvar k = 0; k < 3; k++) begin : gSrc
      localparam int s = (d + k + 1) % numPorts;

      if (d == wordPort) begin : gPack
        wire pkWr;
        wire [wordEntW-1:0] pkData;
        wire [wordEntW-1:0] head;
        wire empty;

        bytePacker uPack (
          .RxClk(RxClk), .arstN(arstN),
          .rxValid(rxValid[s]), .rxD(rxByte[s]), .rxSt(rxSt[s]),
          .wrEn(pkWr), .wrData(pkData)
        );
        pktFifo #(.dataW(wordEntW)) uFifo (
          .RxClk(RxClk), .arstN(arstN),
          .wrEn(pkWr), .wrData(pkData),
          .rdEn(wpPop[k]), .rdData(head), .empty(empty), .full()
        );
        assign wpVld[k] = !empty;
        assign wpD[k]   = head[wordW-1:0];
        assign wpSt[k]  = ethSt'(head[wordEntW-1:wordW]);
      end else if (s == wordPort) begin : gUnpack
        wire [wordEntW-1:0] head;
        wire empty;
        wire upRd;

        pktFifo #(.dataW(wordEntW)) uFifo (   // One whole word per entry
          .RxClk(RxClk), .arstN(arstN),
          .wrEn(rxValid[s]), .wrData({rxSt[s], P3RxD}),
          .rdEn(upRd), .rdData(head), .empty(empty), .full()
        );
        wordUnpacker uUnpk (
          .RxClk(RxClk), .arstN(arstN),
          .fifoEmpty(empty), .fifoData(head),
          .txValid(bpVld[d][k]), .txD(bpD[d][k]), .txSt(bpSt[d][k]),
          .txReady(bpPop[d][k]), .fifoRd(upRd)
        );
      end else begin : gByte
        wire [byteEntW-1:0] head;
        wire empty;

        pktFifo #(.dataW(byteEntW)) uFifo (
          .RxClk(RxClk), .arstN(arstN),
          .wrEn(rxValid[s]), .wrData({rxSt[s], rxByte[s]}),
          .rdEn(bpPop[d][k]), .rdData(head), .empty(empty), .full()
        );
        assign bpVld[d][k] = !empty;
        assign bpD[d][k]   = head[byteW-1:0];
        assign bpSt[d][k]  = ethSt'(head[byteEntW-1:byteW]);
      end
    end
  end

  for (genvar d = 0; d < wordPort; d++) begin : gByteEg
    portEgress #(.dataW(byteW)) uEg (
      .RxClk(RxClk), .arstN(arstN),
      .srcValid(bpVld[d]),
      .srcData0(bpD[d][0]), .srcData1(bpD[d][1]), .srcData2(bpD[d][2]),
      .srcSt0(bpSt[d][0]), .srcSt1(bpSt[d][1]), .srcSt2(bpSt[d][2]),
      .srcPop(bpPop[d]),
      .TxReady(txReady[d]), .TxValid(txValid[d]), .TxD(txByte[d]), .TxSt(txSt[d])
    );
  end

  // Word port egress, sources are ports 0, 1, 2
  portEgress #(.dataW(wordW)) uWordEg (
    .RxClk(RxClk), .arstN(arstN),
    .srcValid(wpVld),
    .srcData0(wpD[0]), .srcData1(wpD[1]), .srcData2(wpD[2]),
    .srcSt0(wpSt[0]), .srcSt1(wpSt[1]), .srcSt2(wpSt[2]),
    .srcPop(wpPop),
    .TxReady(P3TxReady), .TxValid(P3TxValid), .TxD(P3TxD), .TxSt(P3TxSt)
  );

endmodule

`default_nettype wire

// ==== verification/ethSwitch_chk.sv ====
// Transmit-side protocol checks for one switch output.
// Bound into the top level once per port, byte or word width.
`default_nettype none
`timescale 1ns/1ns

module ethSwitch_chk #(
  parameter int dataW = 8
) (
  input wire                    RxClk,
  input wire                    arstN,
  input wire                    txValid,
  input wire                    txReady,
  input wire [dataW-1:0]        txD,
  input wire ethFramePkg::ethSt txSt
);
  import ethFramePkg::*;

  int errCnt = 0;     // Failures so far
  logic inFrame;      // First beat taken, last still to come
  logic accept;

  assign accept = txValid && txReady;

  always_ff @(posedge RxClk or negedge arstN) begin
    if (!arstN) begin
      inFrame <= 1'b0;
    end else if (accept) begin
      inFrame <= (txSt == stFirst) || (inFrame && (txSt == stMid));
    end
  end

  // Output quiet while reset is held
  quietInReset: assert property (@(posedge RxClk) !arstN |-> !txValid)
    else begin
      $error("TxValid high during reset");
      errCnt++;
    end

  holdInStall: assert property (@(posedge RxClk) disable iff (!arstN)
      txValid && !txReady |=> txValid && $stable(txD) && $stable(txSt))
    else begin
      $error("Transmit beat changed during a stall");
      errCnt++;
    end

  // No new frame start before the open one is closed
  noNestedFirst: assert property (@(posedge RxClk) disable iff (!arstN)
      accept && inFrame |-> !((txSt == stFirst) || (txSt == stOnly)))
    else begin
      $error("Frame start inside an open frame");
      errCnt++;
    end

endmodule

bind ethSwitch ethSwitch_chk #(.dataW(8)) uChk0 (
  .RxClk(RxClk), .arstN(arstN), .txValid(P0TxValid), .txReady(P0TxReady),
  .txD(P0TxD), .txSt(P0TxSt)
);
bind ethSwitch ethSwitch_chk #(.dataW(8)) uChk1 (
  .RxClk(RxClk), .arstN(arstN), .txValid(P1TxValid), .txReady(P1TxReady),
  .txD(P1TxD), .txSt(P1TxSt)
);
bind ethSwitch ethSwitch_chk #(.dataW(8)) uChk2 (
  .RxClk(RxClk), .arstN(arstN), .txValid(P2TxValid), .txReady(P2TxReady),
  .txD(P2TxD), .txSt(P2TxSt)
);
bind ethSwitch ethSwitch_chk #(.dataW(16)) uChk3 (   // Word port
  .RxClk(RxClk), .arstN(arstN), .txValid(P3TxValid), .txReady(P3TxReady),
  .txD(P3TxD), .txSt(P3TxSt)
);

`default_nettype wire

// ==== verification/ethSwitchTb.sv ====
// Testbench for the four-port switch.
// Sends frames tagged with their source port on every input and scores each
// output per source against expected queues built from the flood, pack and
// unpack rules. Transmit protocol is watched by the bound checker instances.
`default_nettype none
`timescale 1ns/1ns

module ethSwitchTb;
  import ethFramePkg::*;

  logic RxClk;
  logic arstN;
  logic [3:0] rxValid;
  logic [7:0] rxB [3];          // Byte port receive data
  logic [15:0] rxW;             // Word port receive data
  ethSt rxSt [4];
  logic [3:0] txReady;
  wire [3:0] txValid;
  wire [7:0] txB [3];
  wire [15:0] txW;
  wire ethSt txSt [4];

  int seed = 36317;
  logic bpMode;                 // Random TxReady when set
  logic [17:0] expQ [16][$];    // Status and data, index src*4 + out
  int curSrc [4];               // Source of the frame in progress, -1 if none

  ethSwitch dut (
    .RxClk(RxClk), .arstN(arstN),
    .P0RxValid(rxValid[0]), .P0RxD(rxB[0]), .P0RxSt(rxSt[0]), .P0TxReady(txReady[0]),
    .P0TxValid(txValid[0]), .P0TxD(txB[0]), .P0TxSt(txSt[0]),
    .P1RxValid(rxValid[1]), .P1RxD(rxB[1]), .P1RxSt(rxSt[1]), .P1TxReady(txReady[1]),
    .P1TxValid(txValid[1]), .P1TxD(txB[1]), .P1TxSt(txSt[1]),
    .P2RxValid(rxValid[2]), .P2RxD(rxB[2]), .P2RxSt(rxSt[2]), .P2TxReady(txReady[2]),
    .P2TxValid(txValid[2]), .P2TxD(txB[2]), .P2TxSt(txSt[2]),
    .P3RxValid(rxValid[3]), .P3RxD(rxW), .P3RxSt(rxSt[3]), .P3TxReady(txReady[3]),
    .P3TxValid(txValid[3]), .P3TxD(txW), .P3TxSt(txSt[3])
  );

  initial begin
    RxClk = 1'b0;
    forever #10 RxClk = !RxClk;   // 20 ns period
  end

  // TxReady per output, toggled at random in back-pressure mode
  initial begin
    txReady = 4'hF;
    forever begin
      @(posedge RxClk);
      #2;
      txReady = bpMode ? 4'($random(seed)) : 4'hF;
    end
  end

  function automatic ethSt beatSt(input logic first, input logic last);
    if (first && last) return stOnly;
    if (first) return stFirst;
    if (last) return stLast;
    return stMid;
  endfunction

  // Even frame length, 2 to 16 bytes
  function automatic int lenRand();
    return 2 * (1 + int'(($random(seed) & 32'h7fff_ffff) % 32'd8));
  endfunction

  function automatic int chkErrors();
    return dut.uChk0.errCnt + dut.uChk1.errCnt + dut.uChk2.errCnt + dut.uChk3.errCnt;
  endfunction

  function automatic logic allEmpty();
    foreach (expQ[i]) begin
      if (expQ[i].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic driveBeat(input int p, input logic [15:0] d, input ethSt st);
    rxValid[p] = 1'b1;
    rxSt[p]    = st;
    if (p == wordPort) rxW = d;
    else rxB[p] = d[7:0];
  endtask

  // Queues the expected beats on the three other outputs, then drives the frame
  task automatic sendFrame(input int p, input int nBytes);
    logic [7:0] b [16];
    int nBeats;
    nBeats = (p == wordPort) ? nBytes / 2 : nBytes;
    for (int i = 0; i < nBytes; i++) begin
      b[i] = 8'($random(seed));
    end
    b[0] = 8'(p);                         // Source tag
    for (int d = 0; d < 4; d++) begin
      if (d == p) continue;               // No loopback
      if (d == wordPort) begin
        // Byte pairs, earlier byte on top
        for (int j = 0; j < nBytes / 2; j++) begin
          expQ[p*4+d].push_back({beatSt(j == 0, j == nBytes/2 - 1), b[2*j], b[2*j+1]});
        end
      end else begin
        // Wire byte order, same for words split high then low
        for (int i = 0; i < nBytes; i++) begin
          expQ[p*4+d].push_back({beatSt(i == 0, i == nBytes - 1), 8'h00, b[i]});
        end
      end
    end
    for (int i = 0; i < nBeats; i++) begin
      @(posedge RxClk);
      #2;
      if (p == wordPort) driveBeat(p, {b[2*i], b[2*i+1]}, beatSt(i == 0, i == nBeats - 1));
      else driveBeat(p, {8'h00, b[i]}, beatSt(i == 0, i == nBeats - 1));
    end
    @(posedge RxClk);
    #2;
    rxValid[p] = 1'b0;
  endtask

  task automatic checkBeat(input int d);
    logic [17:0] got;
    logic [17:0] want;
    int s;
    if (d == wordPort) got = {txSt[d], txW};
    else got = {txSt[d], 8'h00, txB[d]};
    if (got[16]) curSrc[d] = (d == wordPort) ? int'(got[15:8]) : int'(got[7:0]);
    s = curSrc[d];
    assert (s >= 0 && s < 4 && s != d && expQ[s*4+d].size() != 0) else
      failRun($sformatf("error at %0t ns: port %0d sent %h with no frame expected",
                        $time, d, got));
    want = expQ[s*4+d].pop_front();
    assert (got == want) else
      failRun($sformatf("error at %0t ns: port %0d from port %0d got %h, expected %h",
                        $time, d, s, got, want));
    if (got[17]) curSrc[d] = -1;          // Frame closed
  endtask

  task automatic waitDrain(input string what);
    int n;
    n = 0;
    while (!allEmpty() && n < 3000) begin
      @(posedge RxClk);
      n++;
    end
    assert (allEmpty()) else
      failRun($sformatf("timeout: outputs did not deliver all %s", what));
    repeat (4) @(posedge RxClk);          // Schedulers back to idle
  endtask

  // Outputs sampled mid-cycle, a beat counts where valid and ready are both high
  always @(negedge RxClk) begin
    if (arstN) begin
      for (int d = 0; d < 4; d++) begin
        if (txValid[d] && txReady[d]) checkBeat(d);
      end
      assert (chkErrors() == 0) else failRun("a transmit protocol assertion failed");
    end
  end

  initial begin
    int lens [4];
    arstN   = 1'b0;
    rxValid = 4'b0000;
    rxW     = 16'h0000;
    bpMode  = 1'b0;
    for (int p = 0; p < 4; p++) begin
      rxSt[p]   = stMid;
      curSrc[p] = -1;
      if (p < 3) rxB[p] = 8'h00;
    end
    repeat (8) @(posedge RxClk);
    #2;
    arstN = 1'b1;
    repeat (6) begin                      // Idle until a frame arrives
      @(negedge RxClk);
      assert (txValid == 4'b0000) else
        failRun($sformatf("error at %0t ns: TxValid %b with no frame sent", $time, txValid));
    end
    sendFrame(0, 10);                     // Flood and pack
    sendFrame(0, 2);
    sendFrame(1, 16);
    waitDrain("byte-port frames");
    sendFrame(3, 12);                     // Unpack
    sendFrame(3, 2);                      // Single word, stOnly
    waitDrain("word-port frames");
    fork                                  // Three sources on each shared output
      sendFrame(0, 16);
      sendFrame(1, 12);
      sendFrame(2, 14);
    join
    waitDrain("simultaneous frames");
    bpMode = 1'b1;
    repeat (6) begin
      for (int p = 0; p < 4; p++) begin
        lens[p] = lenRand();
      end
      fork
        sendFrame(0, lens[0]);
        sendFrame(1, lens[1]);
        sendFrame(2, lens[2]);
        sendFrame(3, lens[3]);
      join
      waitDrain("frames under back-pressure");
    end
    bpMode = 1'b0;
    if (chkErrors() != 0 || !allEmpty()) begin
      failRun("protocol failures or undelivered beats at end of run");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
design/ethFramePkg.sv
design/switchCfgPkg.sv
design/pktFifo.sv
design/bytePacker.sv
design/wordUnpacker.sv
design/portEgress.sv
design/ethSwitch.sv
verification/ethSwitch_chk.sv
verification/ethSwitchTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the switch testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Mdir obj_dir -f src.f --top-module ethSwitchTb -o simv
# The log decides pass or fail, the model may exit nonzero
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
